/* verilog/cpu_pkg.sv */
package cpu_pkg;

    // Width types
    typedef logic [15:0] word_t;
    typedef logic [3:0]  reg_idx_t;
    typedef logic [2:0]  flags_t;

    // Flag bit positions, NVZ order
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_Z = 0;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_XOR  = 4'h2,
        OP_RSV3 = 4'h3,
        OP_SLL  = 4'h4,
        OP_SRA  = 4'h5,
        OP_ROR  = 4'h6,
        OP_RSV7 = 4'h7,
        OP_LW   = 4'h8,
        OP_SW   = 4'h9,
        OP_LLB  = 4'hA,
        OP_LHB  = 4'hB,
        OP_B    = 4'hC,
        OP_BR   = 4'hD,
        OP_PCS  = 4'hE,
        OP_HLT  = 4'hF
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_SLL, ALU_SRA, ALU_ROR, ALU_LLB, ALU_LHB
    } alu_op_e;

    // Branch conditions as encoded in bits 11..9
    typedef enum logic [2:0] {
        COND_NE, COND_EQ, COND_GT, COND_LT, COND_GE, COND_LE, COND_OV, COND_UN
    } cond_e;

endpackage

/* verilog/fetch_unit.sv */
module fetch_unit
    import cpu_pkg::*;
#(
    parameter int IMEM_WORDS = 256
) (
    input  logic  clk,
    input  logic  rst_n,
    input  word_t next_pc,
    input  logic  load_en,
    input  word_t load_addr,
    input  word_t load_data,
    output word_t pc,
    output word_t instr
);

    localparam int IW = $clog2(IMEM_WORDS);

    word_t imem [IMEM_WORDS];

    // PC register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    // Program load port, used while the core sits in reset
    always_ff @(posedge clk) begin
        if (load_en) begin
            imem[load_addr[IW:1]] <= load_data;
        end
    end

    // Word index taken from bits above the byte bit
    assign instr = imem[pc[IW:1]];

endmodule

/* verilog/control.sv */
module control
    import cpu_pkg::*;
(
    input  opcode_e opcode,
    output logic    reg_write,
    output logic    alu_src_imm,
    output logic    mem_read,
    output logic    mem_write,
    output logic    mem_to_reg,
    output logic    pc_to_reg,
    output logic    rd_is_src,
    output logic    branch_imm,
    output logic    branch_reg,
    output logic    halt,
    output logic    flag_update,
    output alu_op_e alu_op
);

    always_comb begin
        reg_write   = 1'b0;
        alu_src_imm = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_to_reg  = 1'b0;
        pc_to_reg   = 1'b0;
        rd_is_src   = 1'b0;
        branch_imm  = 1'b0;
        branch_reg  = 1'b0;
        halt        = 1'b0;
        flag_update = 1'b0;
        alu_op      = ALU_ADD;

        case (opcode)
            OP_ADD, OP_SUB, OP_XOR: begin
                reg_write   = 1'b1;
                flag_update = 1'b1;
                alu_op      = (opcode == OP_ADD) ? ALU_ADD :
                              (opcode == OP_SUB) ? ALU_SUB : ALU_XOR;
            end
            OP_SLL, OP_SRA, OP_ROR: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                flag_update = 1'b1;
                alu_op      = (opcode == OP_SLL) ? ALU_SLL :
                              (opcode == OP_SRA) ? ALU_SRA : ALU_ROR;
            end
            // Address is formed by the ALU adder
            OP_LW: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
                mem_to_reg  = 1'b1;
            end
            OP_SW: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            OP_LLB, OP_LHB: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                rd_is_src   = 1'b1;
                alu_op      = (opcode == OP_LLB) ? ALU_LLB : ALU_LHB;
            end
            OP_B:    branch_imm = 1'b1;
            OP_BR:   branch_reg = 1'b1;
            OP_PCS: begin
                reg_write = 1'b1;
                pc_to_reg = 1'b1;
            end
            OP_HLT:  halt = 1'b1;
            // Reserved codes retire as no-ops
            OP_RSV3, OP_RSV7: ;
            default: ;
        endcase
    end

endmodule

/* verilog/register_file.sv */
module register_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_addr1,
    input  reg_idx_t rd_addr2,
    input  reg_idx_t wr_addr,
    input  logic     wr_en,
    input  word_t    wr_data,
    output word_t    rd_data1,
    output word_t    rd_data2
);

    word_t regs [16];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // R0 never takes a write, so it stays zero after reset
            regs[wr_addr] <= wr_data;
        end
    end

    // Combinational reads, no bypass needed in a single-cycle core
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

endmodule

/* verilog/execute_unit.sv */
module execute_unit
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    input  logic    flag_update,
    output word_t   result,
    output flags_t  flags
);

    word_t       addend;
    word_t       sum;
    logic [31:0] rot;
    logic        ovf;
    logic        zero;

    // SUB reuses the adder with the negated second operand
    assign addend = (op == ALU_SUB) ? (~b + 16'd1) : b;
    assign sum    = a + addend;

    // Equal operand signs, result sign differs
    assign ovf = (a[15] == addend[15]) && (sum[15] != a[15]);

    // Rotate right through a doubled copy
    assign rot = {a, a} >> b[3:0];

    always_comb begin
        case (op)
            ALU_ADD, ALU_SUB: result = sum;
            ALU_XOR:          result = a ^ b;
            ALU_SLL:          result = a << b[3:0];
            ALU_SRA:          result = $unsigned($signed(a) >>> b[3:0]);
            ALU_ROR:          result = rot[15:0];
            // Byte replace, immediate sits in b[7:0]
            ALU_LLB:          result = {a[15:8], b[7:0]};
            ALU_LHB:          result = {b[7:0], a[7:0]};
            default:          result = sum;
        endcase
    end

    assign zero = (result == '0);

    // Flag register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (flag_update) begin
            case (op)
                ALU_ADD, ALU_SUB: begin
                    flags[FLAG_N] <= result[15];
                    flags[FLAG_V] <= ovf;
                    flags[FLAG_Z] <= zero;
                end
                // Logic and shift ops touch Z only
                ALU_XOR, ALU_SLL, ALU_SRA, ALU_ROR: begin
                    flags[FLAG_Z] <= zero;
                end
                default: ;
            endcase
        end
    end

endmodule

/* verilog/pc_control.sv */
module pc_control
    import cpu_pkg::*;
(
    input  word_t  pc,
    input  word_t  offset,
    input  word_t  target,
    input  cond_e  cond,
    input  flags_t flags,
    input  logic   branch_imm,
    input  logic   branch_reg,
    input  logic   halt,
    output word_t  next_pc,
    output word_t  pc_plus2
);

    logic taken;

    assign pc_plus2 = pc + 16'd2;

    always_comb begin
        case (cond)
            COND_NE: taken = !flags[FLAG_Z];
            COND_EQ: taken = flags[FLAG_Z];
            COND_GT: taken = !flags[FLAG_Z] && !flags[FLAG_N];
            COND_LT: taken = flags[FLAG_N];
            COND_GE: taken = flags[FLAG_Z] || !flags[FLAG_N];
            COND_LE: taken = flags[FLAG_N] || flags[FLAG_Z];
            COND_OV: taken = flags[FLAG_V];
            default: taken = 1'b1;
        endcase
    end

    // Halt wins, then taken branches, else fall through
    always_comb begin
        if (halt) begin
            next_pc = pc;
        end else if (branch_imm && taken) begin
            next_pc = pc_plus2 + offset;
        end else if (branch_reg && taken) begin
            next_pc = target;
        end else begin
            next_pc = pc_plus2;
        end
    end

endmodule

/* verilog/data_memory.sv */
module data_memory
    import cpu_pkg::*;
#(
    parameter int DMEM_WORDS = 256
) (
    input  logic  clk,
    input  word_t addr,
    input  word_t wr_data,
    input  logic  wr_en,
    output word_t rd_data
);

    localparam int DW = $clog2(DMEM_WORDS);

    word_t mem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr[DW:1]] <= wr_data;
        end
    end

    // Loads complete in the same cycle
    assign rd_data = mem[addr[DW:1]];

endmodule

/* verilog/cpu.sv */
module cpu
    import cpu_pkg::*;
#(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load_en,
    input  word_t    load_addr,
    input  word_t    load_data,
    output word_t    pc,
    output logic     hlt,
    output logic     wb_en,
    output reg_idx_t wb_reg,
    output word_t    wb_data,
    output logic     st_en,
    output word_t    st_addr,
    output word_t    st_data
);

    word_t    instr;
    word_t    next_pc;
    word_t    pc_plus2;
    opcode_e  opcode;
    cond_e    cond;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd_addr1;
    reg_idx_t rd_addr2;
    word_t    rd_data1;
    word_t    rd_data2;
    word_t    imm_shamt;
    word_t    imm_mem;
    word_t    imm_byte;
    word_t    br_offset;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    flags_t   flags;
    word_t    dmem_rdata;
    logic     mem_access;

    logic     reg_write;
    logic     alu_src_imm;
    logic     mem_read;
    logic     mem_write;
    logic     mem_to_reg;
    logic     pc_to_reg;
    logic     rd_is_src;
    logic     branch_imm;
    logic     branch_reg;
    logic     halt;
    logic     flag_update;
    alu_op_e  alu_op;

    fetch_unit #(.IMEM_WORDS(IMEM_WORDS)) i_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .next_pc   (next_pc),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .instr     (instr)
    );

    // Instruction fields
    assign opcode = opcode_e'(instr[15:12]);
    assign rd     = instr[11:8];
    assign rs     = instr[7:4];
    assign rt     = instr[3:0];
    assign cond   = cond_e'(instr[11:9]);

    control i_control (
        .opcode      (opcode),
        .reg_write   (reg_write),
        .alu_src_imm (alu_src_imm),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_to_reg  (mem_to_reg),
        .pc_to_reg   (pc_to_reg),
        .rd_is_src   (rd_is_src),
        .branch_imm  (branch_imm),
        .branch_reg  (branch_reg),
        .halt        (halt),
        .flag_update (flag_update),
        .alu_op      (alu_op)
    );

    assign hlt = halt;

    // LLB/LHB read rd, SW reads its store data from bits 11..8
    assign rd_addr1 = rd_is_src ? rd : rs;
    assign rd_addr2 = mem_write ? rd : rt;

    register_file i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_addr1 (rd_addr1),
        .rd_addr2 (rd_addr2),
        .wr_addr  (rd),
        .wr_en    (wb_en),
        .wr_data  (wb_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    // Immediates
    assign imm_shamt = {12'b0, instr[3:0]};
    assign imm_mem   = {{11{instr[3]}}, instr[3:0], 1'b0};
    assign imm_byte  = {8'b0, instr[7:0]};
    assign br_offset = {{6{instr[8]}}, instr[8:0], 1'b0};

    assign mem_access = mem_read | mem_write;

    // Memory base is word aligned
    assign alu_a = mem_access ? {rd_data1[15:1], 1'b0} : rd_data1;
    assign alu_b = !alu_src_imm ? rd_data2 :
                   mem_access   ? imm_mem :
                   rd_is_src    ? imm_byte : imm_shamt;

    execute_unit i_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .op          (alu_op),
        .a           (alu_a),
        .b           (alu_b),
        .flag_update (flag_update & ~halt),
        .result      (alu_result),
        .flags       (flags)
    );

    pc_control i_pc_control (
        .pc         (pc),
        .offset     (br_offset),
        .target     (rd_data1),
        .cond       (cond),
        .flags      (flags),
        .branch_imm (branch_imm),
        .branch_reg (branch_reg),
        .halt       (halt),
        .next_pc    (next_pc),
        .pc_plus2   (pc_plus2)
    );

    data_memory #(.DMEM_WORDS(DMEM_WORDS)) i_dmem (
        .clk     (clk),
        .addr    (alu_result),
        .wr_data (rd_data2),
        .wr_en   (st_en),
        .rd_data (dmem_rdata)
    );

    // Write-back and retirement trace
    // Writes aimed at R0 are dropped
    assign wb_en   = reg_write & ~halt & (rd != '0);
    assign wb_reg  = rd;
    assign wb_data = pc_to_reg  ? pc_plus2   :
                     mem_to_reg ? dmem_rdata : alu_result;

    assign st_en   = mem_write & ~halt;
    assign st_addr = alu_result;
    assign st_data = rd_data2;

endmodule

/* sim/cpu_properties.sv */
module cpu_properties
    import cpu_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input word_t    pc,
    input logic     hlt,
    input logic     wb_en,
    input reg_idx_t wb_reg,
    input logic     st_en
);

    timeunit 1ns;
    timeprecision 1ps;

    // A halted core keeps its PC
    assert property (@(posedge clk) disable iff (!rst_n) hlt |=> (pc == $past(pc)))
        else $error("pc changed after a halted cycle");

    // R0 never shows up as a write-back target
    assert property (@(posedge clk) disable iff (!rst_n) !(wb_en && (wb_reg == '0)))
        else $error("register write to R0 on the trace");

    // One instruction never writes both a register and memory
    assert property (@(posedge clk) disable iff (!rst_n) !(wb_en && st_en))
        else $error("register write and store in the same cycle");

endmodule

/* sim/tb_cpu.sv */
module tb_cpu
    import cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROG_WORDS  = 128;
    localparam int BODY_END    = 100;
    localparam int MAX_CYCLES  = 1000;
    localparam int HALT_CYCLES = 20;
    // R13 is the data window base, R14 the register branch target
    localparam reg_idx_t BASE_REG = 4'd13;
    localparam reg_idx_t LINK_REG = 4'd14;

    logic     clk;
    logic     rst_n;
    logic     load_en;
    word_t    load_addr;
    word_t    load_data;
    word_t    pc;
    logic     hlt;
    logic     wb_en;
    reg_idx_t wb_reg;
    word_t    wb_data;
    logic     st_en;
    word_t    st_addr;
    word_t    st_data;

    integer   seed;
    word_t    prog [PROG_WORDS];
    logic     no_br [PROG_WORDS];

    // Reference model state and expected trace
    word_t    m_regs [16];
    word_t    m_mem [256];
    flags_t   m_flags;
    word_t    m_pc;
    word_t    e_pc;
    logic     e_hlt;
    logic     e_wb_en;
    reg_idx_t e_wb_reg;
    word_t    e_wb_data;
    logic     e_st_en;
    word_t    e_st_addr;
    word_t    e_st_data;

    cpu #(.IMEM_WORDS(256), .DMEM_WORDS(256)) i_cpu (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .hlt       (hlt),
        .wb_en     (wb_en),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .st_en     (st_en),
        .st_addr   (st_addr),
        .st_data   (st_data)
    );

    bind cpu cpu_properties i_cpu_properties (
        .clk    (clk),
        .rst_n  (rst_n),
        .pc     (pc),
        .hlt    (hlt),
        .wb_en  (wb_en),
        .wb_reg (wb_reg),
        .st_en  (st_en)
    );

    always #20 clk = ~clk;

    function automatic int unsigned rand_below(int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return r % n;
    endfunction

    function automatic reg_idx_t pick_dest();
        reg_idx_t r;
        r = reg_idx_t'(rand_below(14));
        if (r == 4'd13) begin
            r = 4'd15;
        end
        return r;
    endfunction

    function automatic logic cond_holds(logic [2:0] c, flags_t f);
        logic n;
        logic v;
        logic z;
        logic hold;
        n = f[FLAG_N];
        v = f[FLAG_V];
        z = f[FLAG_Z];
        case (c)
            3'd0:    hold = !z;
            3'd1:    hold = z;
            3'd2:    hold = !z && !n;
            3'd3:    hold = n;
            3'd4:    hold = z || !n;
            3'd5:    hold = n || z;
            3'd6:    hold = v;
            default: hold = 1'b1;
        endcase
        return hold;
    endfunction

    task automatic build_program();
        int          i;
        int          k;
        int          t;
        int unsigned kind;
        reg_idx_t    rd;
        reg_idx_t    rs;
        logic [3:0]  imm4;
        logic [2:0]  c;
        for (int j = 0; j < PROG_WORDS; j++) begin
            prog[j] = {4'hF, 12'h000};
            no_br[j] = 1'b0;
        end
        // Fill all 16 words of the data window before any load
        prog[0] = {4'hA, BASE_REG, 8'h40};
        for (int j = 0; j < 16; j++) begin
            prog[1 + j] = {4'h9, reg_idx_t'(rand_below(16)), BASE_REG, 4'(j)};
        end
        i = 17;
        while (i < BODY_END) begin
            kind = rand_below(16);
            rd = pick_dest();
            rs = reg_idx_t'(rand_below(16));
            imm4 = 4'(rand_below(16));
            c = 3'(rand_below(8));
            case (kind)
                0, 1, 2, 3, 4, 5, 6, 7: prog[i] = {4'(kind), rd, rs, imm4};
                8:       prog[i] = {4'h8, rd, BASE_REG, imm4};
                9:       prog[i] = {4'h9, rs, BASE_REG, imm4};
                10, 11:  prog[i] = {4'(kind), rd, 8'(rand_below(256))};
                12: begin
                    k = int'(rand_below(8));
                    prog[i] = {4'hC, c, 9'(k)};
                    no_br[i + 1 + k] = 1'b1;
                end
                13: begin
                    // A BR reached by a jump would see a stale R14
                    if (!no_br[i + 1]) begin
                        k = int'(rand_below(8));
                        t = i + 2 + k;
                        prog[i] = {4'hA, LINK_REG, 8'(t * 2)};
                        prog[i + 1] = {4'hD, c, 1'b0, LINK_REG, 4'h0};
                        no_br[t] = 1'b1;
                        i = i + 1;
                    end else begin
                        prog[i] = {4'hE, rd, 8'h00};
                    end
                end
                14:      prog[i] = {4'hE, rd, 8'h00};
                default: prog[i] = {4'h0, rd, rs, imm4};
            endcase
            i = i + 1;
        end
    endtask

    // One instruction of the reference interpreter
    task automatic step_model();
        word_t      ins;
        logic [3:0] op;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
        word_t      a;
        word_t      b;
        word_t      nb;
        word_t      res;
        word_t      addr;
        word_t      n_pc;
        logic       v;
        logic       upd_nvz;
        logic       upd_z;
        ins = prog[m_pc[7:1]];
        op = ins[15:12];
        rd = ins[11:8];
        rs = ins[7:4];
        rt = ins[3:0];
        a = m_regs[rs];
        b = m_regs[rt];
        res = '0;
        v = 1'b0;
        upd_nvz = 1'b0;
        upd_z = 1'b0;
        addr = {a[15:1], 1'b0} + {{11{rt[3]}}, rt, 1'b0};
        n_pc = m_pc + 16'd2;
        e_pc = m_pc;
        e_hlt = 1'b0;
        e_wb_en = 1'b0;
        e_wb_reg = rd;
        e_st_en = 1'b0;
        e_st_addr = addr;
        e_st_data = m_regs[rd];
        case (op)
            4'h0: begin
                res = a + b;
                v = (a[15] == b[15]) && (res[15] != a[15]);
                upd_nvz = 1'b1;
                e_wb_en = 1'b1;
            end
            4'h1: begin
                nb = ~b + 16'd1;
                res = a + nb;
                v = (a[15] == nb[15]) && (res[15] != a[15]);
                upd_nvz = 1'b1;
                e_wb_en = 1'b1;
            end
            4'h2, 4'h4, 4'h5, 4'h6: begin
                if (op == 4'h2) begin
                    res = a ^ b;
                end else if (op == 4'h4) begin
                    res = a << rt;
                end else if (op == 4'h5) begin
                    res = word_t'($signed(a) >>> rt);
                end else begin
                    res = (a >> rt) | (a << (5'd16 - {1'b0, rt}));
                end
                upd_z = 1'b1;
                e_wb_en = 1'b1;
            end
            4'h8: begin
                res = m_mem[addr[8:1]];
                e_wb_en = 1'b1;
            end
            4'h9: e_st_en = 1'b1;
            4'hA: begin
                res = {m_regs[rd][15:8], ins[7:0]};
                e_wb_en = 1'b1;
            end
            4'hB: begin
                res = {ins[7:0], m_regs[rd][7:0]};
                e_wb_en = 1'b1;
            end
            4'hC: begin
                if (cond_holds(ins[11:9], m_flags)) begin
                    n_pc = m_pc + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
                end
            end
            4'hD: begin
                if (cond_holds(ins[11:9], m_flags)) begin
                    n_pc = m_regs[rs];
                end
            end
            4'hE: begin
                res = m_pc + 16'd2;
                e_wb_en = 1'b1;
            end
            4'hF: begin
                n_pc = m_pc;
                e_hlt = 1'b1;
            end
            default: ;
        endcase
        e_wb_data = res;
        // A write to R0 is discarded and leaves no write strobe
        if (rd == 4'd0) begin
            e_wb_en = 1'b0;
        end
        if (e_wb_en) begin
            m_regs[rd] = res;
        end
        if (e_st_en) begin
            m_mem[addr[8:1]] = e_st_data;
        end
        if (upd_nvz) begin
            m_flags[FLAG_N] = res[15];
            m_flags[FLAG_V] = v;
            m_flags[FLAG_Z] = (res == '0);
        end else if (upd_z) begin
            m_flags[FLAG_Z] = (res == '0);
        end
        m_pc = n_pc;
    endtask

    task automatic check(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERR %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "DUT output differs from the reference model");
        end
    endtask

    task automatic check_trace();
        check("pc", pc, e_pc);
        check("hlt", word_t'(hlt), word_t'(e_hlt));
        check("wb_en", word_t'(wb_en), word_t'(e_wb_en));
        check("st_en", word_t'(st_en), word_t'(e_st_en));
        if (e_wb_en) begin
            check("wb_reg", word_t'(wb_reg), word_t'(e_wb_reg));
            check("wb_data", wb_data, e_wb_data);
        end
        if (e_st_en) begin
            check("st_addr", st_addr, e_st_addr);
            check("st_data", st_data, e_st_data);
        end
    endtask

    initial begin
        int cycles;
        int halted;
        clk = 1'b0;
        rst_n = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed = 32'h970e_f7a4;
        for (int j = 0; j < 16; j++) begin
            m_regs[j] = '0;
        end
        m_flags = '0;
        m_pc = '0;
        build_program();

        // Program goes in while the core is held in reset
        for (int j = 0; j < PROG_WORDS; j++) begin
            @(posedge clk);
            #1;
            load_en = 1'b1;
            load_addr = word_t'(2 * j);
            load_data = prog[j];
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Halt cycle plus the hold period after it
        cycles = 0;
        halted = 0;
        while ((halted <= HALT_CYCLES) && (cycles < MAX_CYCLES)) begin
            @(negedge clk);
            step_model();
            check_trace();
            if (e_hlt) begin
                halted++;
            end
            cycles++;
        end

        if (halted <= HALT_CYCLES) begin
            $display("The core never halted within %0d cycles", MAX_CYCLES);
            $display("Test FAILED");
            $fatal(1, "timeout waiting for halt");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* sources.f */
verilog/cpu_pkg.sv
verilog/fetch_unit.sv
verilog/control.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/pc_control.sv
verilog/data_memory.sv
verilog/cpu.sv
sim/cpu_properties.sv
sim/tb_cpu.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_cpu
FILELIST  := sources.f
OBJ_DIR   := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
